// ==== common/flush_defs.svh ====
// Flush controller constants shared by RTL and testbench
`ifndef FLUSH_DEFS_SVH
`define FLUSH_DEFS_SVH

// Virtual address width of PC and restart address
`define FLUSH_VLEN 32

// Drain counter value that ends draining, 16 idle cycles in total
`define FENCE_T_DRAIN_MAX 15

// Cycles with the micro-architectural reset held low
`define FENCE_T_RST_CYCLES 16

// Width of the cache-init hold shift register
`define CACHE_INIT_HOLD 3

`endif

// ==== common/flush_pkg.sv ====
// Flush controller package with privilege and fence.t state types
package flush_pkg;

  // RISC-V privilege level, encoded as in mstatus.MPP
  typedef enum logic [1:0] {
    PRIV_LVL_U = 2'b00,
    PRIV_LVL_S = 2'b01,
    PRIV_LVL_M = 2'b11
  } priv_lvl_e;

  // fence.t sequencer states
  typedef enum logic [2:0] {
    FT_IDLE         = 3'd0,  // Waiting for fence.t
    FT_FLUSH_DCACHE = 3'd1,  // Waiting for the dcache flush ack
    FT_DRAIN        = 3'd2,  // Cache must stay idle long enough
    FT_PAD          = 3'd3,  // Padding count running out
    FT_RST_UARCH    = 3'd4   // Micro-reset held low
  } fence_t_state_e;

endpackage

// ==== common/flush_cmd_if.sv ====
// Control levels shared by flush decoder, dcache fence unit and fence.t sequencer
interface flush_cmd_if;

  logic dcache_req;     // One-cycle dcache flush request from the decoder
  logic fence_t_start;  // One-cycle fence.t start strobe
  logic fence_active;   // Dcache flush waiting for its ack
  logic seq_busy;       // fence.t sequencer not idle

  // Decoder raises requests, watches both busy levels for halt
  modport decoder (
    output dcache_req,
    output fence_t_start,
    input  fence_active,
    input  seq_busy
  );

  modport cache (
    input  dcache_req,
    output fence_active
  );

  modport seq (
    input  fence_t_start,
    output seq_busy
  );

endinterface

// ==== logic/updown_counter.sv ====
// Generic up/down counter with synchronous clear, load and enable
module updown_counter #(
  parameter int unsigned WIDTH = 4
) (
  input  logic             clk_i,
  input  logic             rst_ni,
  input  logic             clear_i,  // Highest priority, back to zero
  input  logic             en_i,     // Count step enable
  input  logic             load_i,   // Load d_i, wins over counting
  input  logic             down_i,   // Count direction
  input  logic [WIDTH-1:0] d_i,
  output logic [WIDTH-1:0] q_o
);

  logic [WIDTH-1:0] cnt_d, cnt_q;

  // Next value, clear before load before count
  always_comb begin
    cnt_d = cnt_q;
    if (clear_i) begin
      cnt_d = '0;
    end else if (load_i) begin
      cnt_d = d_i;
    end else if (en_i) begin
      cnt_d = down_i ? cnt_q - WIDTH'(1) : cnt_q + WIDTH'(1);  // Wraps, callers gate en_i
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      cnt_q <= '0;
    end else begin
      cnt_q <= cnt_d;
    end
  end

  assign q_o = cnt_q;

endmodule

// ==== flush_ctrl/flush_decoder.sv ====
// Flush decoder, turns pipeline events into stage flush strobes, halt and restart address
`include "flush_defs.svh"

module flush_decoder (
  input  logic                   clk_i,
  input  logic                   rst_ni,
  input  logic                   mispredict_i,
  input  logic                   fence_i,
  input  logic                   fence_i_i,
  input  logic                   sfence_vma_i,
  input  logic                   fence_t_i,
  input  logic                   flush_csr_i,
  input  logic                   ex_valid_i,
  input  logic                   eret_i,
  input  logic                   set_debug_pc_i,
  input  logic                   halt_csr_i,
  input  logic [`FLUSH_VLEN-1:0] boot_addr_i,
  input  logic [`FLUSH_VLEN-1:0] pc_commit_i,
  output logic                   set_pc_commit_o,         // PC gen restarts from commit PC
  output logic                   flush_if_o,
  output logic                   flush_unissued_instr_o,  // Scoreboard entries not yet issued
  output logic                   flush_id_o,
  output logic                   flush_ex_o,
  output logic                   flush_bp_o,
  output logic                   flush_icache_o,
  output logic                   flush_tlb_o,
  output logic                   halt_o,
  output logic [`FLUSH_VLEN-1:0] rst_addr_o,
  flush_cmd_if.decoder           cmd
);

  logic                   dcache_req;
  logic                   fence_t_start;
  logic                   full_flush;  // Commit PC plus IF, ID, EX, un-issued
  logic [`FLUSH_VLEN-1:0] rst_addr_d, rst_addr_q;

  // Events that behave like a CSR instruction with side effect
  assign full_flush = fence_i | fence_i_i | sfence_vma_i | flush_csr_i;

  // --------------------------------------------------------------------------
  // Event decode, later groups override earlier ones
  // --------------------------------------------------------------------------
  always_comb begin
    set_pc_commit_o        = 1'b0;
    flush_if_o             = 1'b0;
    flush_unissued_instr_o = 1'b0;
    flush_id_o             = 1'b0;
    flush_ex_o             = 1'b0;
    flush_bp_o             = 1'b0;
    flush_icache_o         = 1'b0;
    flush_tlb_o            = 1'b0;
    dcache_req             = 1'b0;
    fence_t_start          = 1'b0;
    rst_addr_d             = rst_addr_q;

    // Mispredict, front end only
    if (mispredict_i) begin
      flush_if_o             = 1'b1;
      flush_unissued_instr_o = 1'b1;
    end

    if (full_flush) begin
      set_pc_commit_o        = 1'b1;
      flush_if_o             = 1'b1;
      flush_unissued_instr_o = 1'b1;
      flush_id_o             = 1'b1;
      flush_ex_o             = 1'b1;
    end

    if (fence_i || fence_i_i) dcache_req = 1'b1;     // Write-back dcache must be cleaned
    if (fence_i_i) flush_icache_o = 1'b1;
    if (sfence_vma_i) flush_tlb_o = 1'b1;

    // fence.t, both caches plus the micro-reset sequence
    if (fence_t_i) begin
      flush_icache_o = 1'b1;
      dcache_req     = 1'b1;
      fence_t_start  = 1'b1;
      rst_addr_d     = pc_commit_i + {{(`FLUSH_VLEN - 3) {1'b0}}, 3'b100};  // Resume after it
    end

    // Exception, eret, debug entry
    // PC gen takes the trap PC, so no commit PC here
    if (ex_valid_i || eret_i || set_debug_pc_i) begin
      set_pc_commit_o        = 1'b0;
      flush_if_o             = 1'b1;
      flush_unissued_instr_o = 1'b1;
      flush_id_o             = 1'b1;
      flush_ex_o             = 1'b1;
      flush_bp_o             = 1'b1;  // No stale speculative fetches across privilege change
    end
  end

  assign cmd.dcache_req    = dcache_req;
  assign cmd.fence_t_start = fence_t_start;

  // Commit stage stops while any cache sequence runs
  assign halt_o = halt_csr_i | cmd.fence_active | cmd.seq_busy;

  // Restart address after micro-reset
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rst_addr_q <= boot_addr_i;
    end else begin
      rst_addr_q <= rst_addr_d;
    end
  end

  assign rst_addr_o = rst_addr_q;

endmodule

// ==== flush_ctrl/dcache_fence.sv ====
// Data-cache fence unit, registered flush request held until the cache acknowledges
module dcache_fence (
  input  logic       clk_i,
  input  logic       rst_ni,
  input  logic       flush_dcache_ack_i,
  output logic       flush_dcache_o,  // Level to the dcache, registered
  flush_cmd_if.cache cmd
);

  logic fence_active_d, fence_active_q;
  logic flush_dcache;

  always_comb begin
    fence_active_d = fence_active_q;
    flush_dcache   = 1'b0;
    if (cmd.dcache_req) begin
      fence_active_d = 1'b1;
      flush_dcache   = 1'b1;
    end
    // Ack ends the fence, otherwise keep asking
    if (fence_active_q && flush_dcache_ack_i) begin
      fence_active_d = 1'b0;
    end else if (fence_active_q) begin
      flush_dcache = 1'b1;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      fence_active_q <= 1'b0;
      flush_dcache_o <= 1'b0;
    end else begin
      fence_active_q <= fence_active_d;
      flush_dcache_o <= flush_dcache;  // Flop keeps the dcache path short
    end
  end

  assign cmd.fence_active = fence_active_q;

endmodule

// ==== fence_t/pad_timer.sv ====
// fence.t padding timer, down-counter started by a timer irq edge or a U-mode exit
module pad_timer
  import flush_pkg::*;
(
  input  logic        clk_i,
  input  logic        rst_ni,
  input  logic        time_irq_i,         // CLINT timer interrupt level
  input  priv_lvl_e   priv_lvl_i,
  input  logic        fence_t_src_sel_i,  // 0 timer irq edge, 1 leaving U-mode
  input  logic [31:0] fence_t_pad_i,      // Padding length in cycles
  output logic [31:0] pad_cnt_o
);

  logic      time_irq_q;
  priv_lvl_e priv_lvl_q;
  logic      load_pad;
  logic      irq_rise;
  logic      user_exit;

  assign irq_rise  = time_irq_i & ~time_irq_q;
  assign user_exit = (priv_lvl_q == PRIV_LVL_U) && (priv_lvl_i != PRIV_LVL_U);
  assign load_pad  = fence_t_src_sel_i ? user_exit : irq_rise;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      time_irq_q <= 1'b0;
      priv_lvl_q <= PRIV_LVL_M;  // Core leaves reset in M-mode
    end else begin
      time_irq_q <= time_irq_i;
      priv_lvl_q <= priv_lvl_i;
    end
  end

  // Count down to zero and stop there
  updown_counter #(
    .WIDTH (32)
  ) i_pad_cnt (
    .clk_i,
    .rst_ni,
    .clear_i (1'b0),
    .en_i    (|pad_cnt_o),
    .load_i  (load_pad),
    .down_i  (1'b1),
    .d_i     (fence_t_pad_i),
    .q_o     (pad_cnt_o)
  );

endmodule

// ==== fence_t/fence_t_fsm.sv ====
// fence.t sequencer, dcache flush, drain, padding and timed micro-architectural reset
`include "flush_defs.svh"

module fence_t_fsm
  import flush_pkg::*;
(
  input  logic        clk_i,
  input  logic        rst_ni,
  input  logic        flush_dcache_ack_i,
  input  logic        cache_busy_i,      // Restarts the drain count
  input  logic [31:0] fence_t_pad_i,
  input  logic [31:0] pad_cnt_i,         // Remaining padding from pad_timer
  output logic        rst_uarch_no,      // Active low micro-reset
  output logic        cache_init_no,     // Keep caches from initialising
  output logic        stall_cache_o,
  output logic [31:0] fence_t_ceil_o,    // Padding already consumed, drain exit only
  flush_cmd_if.seq    cmd
);

  fence_t_state_e                        state_d, state_q;
  logic [3:0]                            drain_cnt;
  logic [3:0]                            rst_cnt_d, rst_cnt_q;
  logic [`CACHE_INIT_HOLD-1:0]           cache_init_d, cache_init_q;
  logic                                  in_rst;

  // Drain counter, cache must be idle 16 cycles in a row
  updown_counter #(
    .WIDTH (4)
  ) i_drain_cnt (
    .clk_i,
    .rst_ni,
    .clear_i (cache_busy_i),                         // Busy restarts from zero
    .en_i    (drain_cnt != 4'(`FENCE_T_DRAIN_MAX)),  // Saturate at the limit
    .load_i  (1'b0),
    .down_i  (1'b0),
    .d_i     (4'b0),
    .q_o     (drain_cnt)
  );

  // --------------------------------------------------------------------------
  // Sequencer
  // --------------------------------------------------------------------------
  always_comb begin
    state_d        = state_q;
    rst_cnt_d      = rst_cnt_q;
    in_rst         = 1'b0;
    fence_t_ceil_o = '0;

    unique case (state_q)
      FT_IDLE: begin
        if (cmd.fence_t_start) state_d = FT_FLUSH_DCACHE;
      end
      FT_FLUSH_DCACHE: begin
        if (flush_dcache_ack_i) state_d = FT_DRAIN;  // Dcache written back
      end
      FT_DRAIN: begin
        if (drain_cnt == 4'(`FENCE_T_DRAIN_MAX)) begin
          state_d = FT_PAD;
          // Zero when padding already expired
          fence_t_ceil_o = (pad_cnt_i == '0) ? '0 : fence_t_pad_i - pad_cnt_i;
        end
      end
      FT_PAD: begin
        if (pad_cnt_i == '0) state_d = FT_RST_UARCH;
      end
      FT_RST_UARCH: begin
        in_rst = 1'b1;
        if (rst_cnt_q == 4'(`FENCE_T_RST_CYCLES - 1)) begin
          rst_cnt_d = 4'b0;
          state_d   = FT_IDLE;
        end else begin
          rst_cnt_d = rst_cnt_q + 4'd1;
        end
      end
      default: begin
        state_d = FT_IDLE;  // Unused encodings recover to idle
      end
    endcase
  end

  assign rst_uarch_no = ~in_rst;

  // Cache init held off through reset plus the shift register depth
  assign cache_init_d  = {cache_init_q[`CACHE_INIT_HOLD-2:0], in_rst};
  assign cache_init_no = in_rst | (|cache_init_q);

  // Busy covers the whole sequence, caches take no new requests
  assign cmd.seq_busy  = (state_q != FT_IDLE);
  assign stall_cache_o = cmd.seq_busy;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q      <= FT_IDLE;
      rst_cnt_q    <= 4'b0;
      cache_init_q <= '0;
    end else begin
      state_q      <= state_d;
      rst_cnt_q    <= rst_cnt_d;
      cache_init_q <= cache_init_d;
    end
  end

endmodule

// ==== logic/flush_ctrl_top.sv ====
// Flush and micro-reset controller of the in-order core, plain-port top level
`include "flush_defs.svh"

module flush_ctrl_top
  import flush_pkg::*;
(
  input  logic                   clk_i,
  input  logic                   rst_ni,
  input  logic [`FLUSH_VLEN-1:0] boot_addr_i,
  input  logic [`FLUSH_VLEN-1:0] pc_commit_i,
  input  logic                   mispredict_i,        // Resolved branch was mispredicted
  input  logic                   fence_i,             // fence
  input  logic                   fence_i_i,           // fence.i
  input  logic                   sfence_vma_i,        // sfence.vma
  input  logic                   fence_t_i,           // fence.t
  input  logic                   flush_csr_i,         // CSR write with side effect
  input  logic                   ex_valid_i,          // Exception taken
  input  logic                   eret_i,              // Return from exception
  input  logic                   set_debug_pc_i,      // Debug entry
  input  logic                   halt_csr_i,          // WFI halt from CSR file
  input  logic                   flush_dcache_ack_i,
  input  logic                   cache_busy_i,
  input  logic                   time_irq_i,
  input  priv_lvl_e              priv_lvl_i,
  input  logic [31:0]            fence_t_pad_i,       // Pad cycles relative to the trigger
  input  logic                   fence_t_src_sel_i,   // 0 timer irq, 1 leaving U-mode
  output logic                   set_pc_commit_o,
  output logic                   flush_if_o,
  output logic                   flush_unissued_instr_o,
  output logic                   flush_id_o,
  output logic                   flush_ex_o,
  output logic                   flush_bp_o,
  output logic                   flush_icache_o,
  output logic                   flush_tlb_o,
  output logic                   flush_dcache_o,
  output logic                   halt_o,
  output logic                   stall_cache_o,
  output logic                   cache_init_no,
  output logic                   rst_uarch_no,
  output logic [`FLUSH_VLEN-1:0] rst_addr_o,
  output logic [31:0]            fence_t_ceil_o
);

  flush_cmd_if cmd ();  // Decoder, cache fence and sequencer handshake

  logic [31:0] pad_cnt;  // Remaining padding cycles

  flush_decoder i_flush_decoder (
    .clk_i,
    .rst_ni,
    .mispredict_i,
    .fence_i,
    .fence_i_i,
    .sfence_vma_i,
    .fence_t_i,
    .flush_csr_i,
    .ex_valid_i,
    .eret_i,
    .set_debug_pc_i,
    .halt_csr_i,
    .boot_addr_i,
    .pc_commit_i,
    .set_pc_commit_o,
    .flush_if_o,
    .flush_unissued_instr_o,
    .flush_id_o,
    .flush_ex_o,
    .flush_bp_o,
    .flush_icache_o,
    .flush_tlb_o,
    .halt_o,
    .rst_addr_o,
    .cmd                    (cmd.decoder)
  );

  dcache_fence i_dcache_fence (
    .clk_i,
    .rst_ni,
    .flush_dcache_ack_i,
    .flush_dcache_o,
    .cmd                (cmd.cache)
  );

  fence_t_fsm i_fence_t_fsm (
    .clk_i,
    .rst_ni,
    .flush_dcache_ack_i,
    .cache_busy_i,
    .fence_t_pad_i,
    .pad_cnt_i          (pad_cnt),
    .rst_uarch_no,
    .cache_init_no,
    .stall_cache_o,
    .fence_t_ceil_o,
    .cmd                (cmd.seq)
  );

  pad_timer i_pad_timer (
    .clk_i,
    .rst_ni,
    .time_irq_i,
    .priv_lvl_i,
    .fence_t_src_sel_i,
    .fence_t_pad_i,
    .pad_cnt_o         (pad_cnt)
  );

endmodule

// ==== test/flush_ctrl_chk.sv ====
// Bound assertions on the fence.t sequencer and the dcache fence unit
`include "flush_defs.svh"

module flush_ctrl_chk
  import flush_pkg::*;
(
  input logic           clk_i,
  input logic           rst_ni,
  input fence_t_state_e state_i,
  input logic [3:0]     drain_cnt_i,
  input logic           rst_uarch_ni,
  input logic           flush_req_i,     // Registered dcache flush request
  input logic           fence_active_i,
  input logic           ack_i
);
  timeunit 1ns;
  timeprecision 100ps;

  // Micro-reset only inside the reset state, and that state is entered from padding
  assert property (@(posedge clk_i) disable iff (!rst_ni)
    !rst_uarch_ni |-> state_i == FT_RST_UARCH &&
                      ($past(state_i) == FT_PAD || $past(state_i) == FT_RST_UARCH))
    else $error("micro-reset low outside reset state");

  // Drain is left only at the drain limit
  assert property (@(posedge clk_i) disable iff (!rst_ni)
    (state_i == FT_DRAIN && drain_cnt_i != 4'(`FENCE_T_DRAIN_MAX)) |=> state_i == FT_DRAIN)
    else $error("drain left before limit");

  // Request held while waiting for the ack
  assert property (@(posedge clk_i) disable iff (!rst_ni)
    (fence_active_i && !ack_i) |=> flush_req_i)
    else $error("dcache flush request dropped before ack");

endmodule

bind fence_t_fsm flush_ctrl_chk i_fsm_chk (
  .clk_i,
  .rst_ni,
  .state_i        (state_q),
  .drain_cnt_i    (drain_cnt),
  .rst_uarch_ni   (rst_uarch_no),
  .flush_req_i    (1'b0),
  .fence_active_i (1'b0),
  .ack_i          (1'b0)
);

bind dcache_fence flush_ctrl_chk i_fence_chk (
  .clk_i,
  .rst_ni,
  .state_i        (flush_pkg::FT_IDLE),
  .drain_cnt_i    (4'd0),
  .rst_uarch_ni   (1'b1),
  .flush_req_i    (flush_dcache_o),
  .fence_active_i (fence_active_q),
  .ack_i          (flush_dcache_ack_i)
);

// ==== test/flush_ctrl_tb.sv ====
// Testbench for the flush controller, file driven with LFSR ack delays and busy bursts
`include "flush_defs.svh"

module flush_ctrl_tb
  import flush_pkg::*;
;
  timeunit 1ns;
  timeprecision 100ps;

  localparam int INIT_TAIL = 3;  // cache_init_no cycles past micro-reset

  logic clk_i = 1'b0;
  logic rst_ni;
  logic [`FLUSH_VLEN-1:0] boot_addr_i, pc_commit_i, rst_addr_o;
  logic mispredict_i, fence_i, fence_i_i, sfence_vma_i, fence_t_i, flush_csr_i;
  logic ex_valid_i, eret_i, set_debug_pc_i, halt_csr_i;
  logic flush_dcache_ack_i, cache_busy_i, time_irq_i, fence_t_src_sel_i;
  priv_lvl_e priv_lvl_i;
  logic [31:0] fence_t_pad_i, fence_t_ceil_o;
  logic set_pc_commit_o, flush_if_o, flush_unissued_instr_o, flush_id_o, flush_ex_o;
  logic flush_bp_o, flush_icache_o, flush_tlb_o, flush_dcache_o, halt_o, stall_cache_o;
  logic cache_init_no, rst_uarch_no;

  logic [15:0] lfsr = 16'd97;
  int          errors = 0;
  int          checks = 0;
  int          cyc = 0;
  int          limit = 0;  // Zero until the stimulus is loaded
  logic [31:0] q_code[$], q_op1[$], q_op2[$], q_op3[$], q_op4[$], q_op5[$];

  always #4 clk_i = ~clk_i;

  flush_ctrl_top i_flush_ctrl_top (.*);

  // Watchdog
  always @(posedge clk_i) begin
    cyc <= cyc + 1;
    if (limit != 0 && cyc >= limit) begin
      $display("Timeout, the run took longer than %0d cycles", limit);
      $display("Something failed");
      $finish;
    end
  end

  // Galois LFSR, taps 16,14,13,11
  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    lfsr_next = s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
  endfunction

  task automatic rand_bits(input int n, output logic [31:0] v);
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr = lfsr_next(lfsr);  // One step per bit
      v    = {v[30:0], lfsr[0]};
    end
  endtask

  task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
    checks++;
    if (got !== exp) begin
      $display("FAILED %s: got %h, expected %h", name, got, exp);
      errors++;
    end
  endtask

  task automatic drive_events(input logic [7:0] mask);
    mispredict_i   <= mask[0];
    fence_i        <= mask[1];
    fence_i_i      <= mask[2];
    sfence_vma_i   <= mask[3];
    flush_csr_i    <= mask[4];
    ex_valid_i     <= mask[5];
    eret_i         <= mask[6];
    set_debug_pc_i <= mask[7];
  endtask

  task automatic load_stim();
    int    fd;
    int    n;
    string line;
    logic [31:0] c, a, b, d, e, f, g;
    fd = $fopen("test/flush_ctrl_stim.txt", "r");
    if (fd == 0) begin
      $display("Could not open the stimulus file");
      errors++;
    end else begin
      while (!$feof(fd)) begin
        n = $fgets(line, fd);
        if (n > 1 && line[0] != "#") begin
          n = $sscanf(line, "%h %h %h %h %h %h %h", c, a, b, d, e, f, g);
          if (n == 7) begin
            q_code.push_back(c);
            q_op1.push_back(a);
            q_op2.push_back(b);
            q_op3.push_back(d);
            q_op4.push_back(e);
            q_op5.push_back(f);
            limit += g;  // Per-test cycle bound
          end
        end
      end
      $fclose(fd);
    end
  endtask

  // -------------------------------------------------------------------------
  // Test tasks
  // -------------------------------------------------------------------------
  task automatic run_reset(input logic [31:0] exp_addr);
    @(posedge clk_i);
    rst_ni <= 1'b0;
    repeat (4) @(posedge clk_i);
    rst_ni <= 1'b1;
    @(negedge clk_i);
    check("halt_o", halt_o, 0);
    check("flush_dcache_o", flush_dcache_o, 0);
    check("stall_cache_o", stall_cache_o, 0);
    check("rst_uarch_no", rst_uarch_no, 1);
    check("cache_init_no", cache_init_no, 0);
    check("rst_addr_o", rst_addr_o, exp_addr);
  endtask

  task automatic run_event(input logic [7:0] mask, input logic [7:0] exp_strb,
                           input logic exp_dc);
    logic [31:0] dly;
    @(posedge clk_i);
    drive_events(mask);
    @(negedge clk_i);
    check("flush strobes", {set_pc_commit_o, flush_if_o, flush_unissued_instr_o, flush_id_o,
                            flush_ex_o, flush_bp_o, flush_icache_o, flush_tlb_o}, exp_strb);
    @(posedge clk_i);
    drive_events(8'h00);
    @(negedge clk_i);
    check("flush_dcache_o", flush_dcache_o, exp_dc);
    check("halt_o", halt_o, exp_dc);
    if (exp_dc) begin
      rand_bits(3, dly);  // Ack delay
      for (int i = 0; i < dly; i++) begin
        @(negedge clk_i);
        check("flush_dcache_o", flush_dcache_o, 1);
      end
      @(posedge clk_i);
      flush_dcache_ack_i <= 1'b1;
      @(negedge clk_i);
      check("flush_dcache_o", flush_dcache_o, 1);
      check("halt_o", halt_o, 1);
      @(posedge clk_i);
      flush_dcache_ack_i <= 1'b0;
      @(negedge clk_i);
      check("flush_dcache_o", flush_dcache_o, 0);
      check("halt_o", halt_o, 0);
    end
  endtask

  task automatic run_fence_t(input logic sel, input logic [31:0] pad, input int trig,
                             input logic bursts, input logic [31:0] pc);
    int          k, ack_k, phase, run, low_cnt, tail_cnt;
    logic        seen_low, seq_done, done, exit_now, exit_seen, busy;
    logic [31:0] r, cnt_m, exp_ceil;
    k = 0;
    phase = 0;
    run = `FENCE_T_DRAIN_MAX;  // Cache idle long before the start
    low_cnt = 0;
    tail_cnt = 0;
    seen_low = 0;
    seq_done = 0;
    done = 0;
    exit_now = 0;
    exit_seen = 0;
    rand_bits(3, r);
    ack_k = 4 + r;
    @(posedge clk_i);
    pc_commit_i       <= pc;
    fence_t_src_sel_i <= sel;
    fence_t_pad_i     <= pad;
    priv_lvl_i        <= PRIV_LVL_U;
    time_irq_i        <= 1'b0;
    cache_busy_i      <= 1'b0;
    repeat (16) @(posedge clk_i);
    while (!done) begin
      @(posedge clk_i);
      // Idle run of the cache as seen over the last cycle
      if (cache_busy_i) run = 0;
      else if (run != `FENCE_T_DRAIN_MAX) run++;
      if (exit_now) phase = 2;
      if (phase == 0 && k > 0 && flush_dcache_ack_i) phase = 1;
      exit_now = (phase == 1) && (run == `FENCE_T_DRAIN_MAX);
      busy = 1'b0;
      if (bursts && k > 0 && k < 30) begin
        rand_bits(2, r);
        busy = &r[1:0];
      end
      fence_t_i          <= (k == 0);
      flush_dcache_ack_i <= (k == ack_k);
      cache_busy_i       <= busy;
      if (k == trig) begin
        if (sel) priv_lvl_i <= PRIV_LVL_M;
        else time_irq_i <= 1'b1;
      end
      // Padding count loads at the edge after the trigger cycle
      cnt_m = (k > trig && pad > k - trig - 1) ? pad - (k - trig - 1) : 0;
      exp_ceil = (exit_now && cnt_m != 0) ? pad - cnt_m : 0;
      @(negedge clk_i);
      check("fence_t_ceil_o", fence_t_ceil_o, exp_ceil);
      if (exit_now) exit_seen = 1;
      if (k == 1) check("rst_addr_o", rst_addr_o, pc + 4);
      if (!rst_uarch_no) begin
        low_cnt++;
        seen_low = 1;
        check("cache_init_no", cache_init_no, 1);
      end else if (seen_low) begin
        seq_done = 1;
        if (cache_init_no) tail_cnt++;
        else done = 1;
      end
      if (k >= 1) begin
        check("stall_cache_o", stall_cache_o, !seq_done);
        check("halt_o", halt_o, !seq_done);
      end
      k++;
    end
    check("rst_uarch_no low cycles", low_cnt, `FENCE_T_RST_CYCLES);
    check("cache_init_no tail cycles", tail_cnt, INIT_TAIL);
    if (!exit_seen) begin
      $display("The drain step never ended in the expected window");
      errors++;
    end
    @(posedge clk_i);
    time_irq_i <= 1'b0;
  endtask

  // -------------------------------------------------------------------------
  // Main sequence
  // -------------------------------------------------------------------------
  initial begin
    int err_before;
    rst_ni = 1'b0;
    boot_addr_i = 32'h8000_0000;
    pc_commit_i = '0;
    mispredict_i = 0;
    fence_i = 0;
    fence_i_i = 0;
    sfence_vma_i = 0;
    fence_t_i = 0;
    flush_csr_i = 0;
    ex_valid_i = 0;
    eret_i = 0;
    set_debug_pc_i = 0;
    halt_csr_i = 0;
    flush_dcache_ack_i = 0;
    cache_busy_i = 0;
    time_irq_i = 0;
    priv_lvl_i = PRIV_LVL_U;
    fence_t_pad_i = '0;
    fence_t_src_sel_i = 0;
    load_stim();
    limit += 50;  // Margin for initial reset and report
    repeat (4) @(posedge clk_i);
    rst_ni <= 1'b1;
    for (int t = 0; t < q_code.size(); t++) begin
      err_before = errors;
      case (q_code[t])
        0: run_reset(q_op1[t]);
        1: run_event(q_op1[t][7:0], q_op2[t][7:0], q_op3[t][0]);
        2: run_fence_t(q_op1[t][0], q_op2[t], q_op3[t], q_op4[t][0], q_op5[t]);
        default: begin
          $display("Unknown command code in stimulus line %0d", t);
          errors++;
        end
      endcase
      $display("Test %0d code %0d done, %0d errors", t, q_code[t], errors - err_before);
    end
    $display("Tests %0d, checks %0d, errors %0d", q_code.size(), checks, errors);
    if (errors == 0 && q_code.size() > 0) begin
      $display("Everything OK");
    end else begin
      $display("Something failed");
    end
    $finish;
  end

endmodule

// ==== flush_ctrl_top.f ====
common/flush_pkg.sv
common/flush_cmd_if.sv
logic/updown_counter.sv
flush_ctrl/flush_decoder.sv
flush_ctrl/dcache_fence.sv
fence_t/pad_timer.sv
fence_t/fence_t_fsm.sv
logic/flush_ctrl_top.sv
test/flush_ctrl_chk.sv
test/flush_ctrl_tb.sv
+incdir+common

// ==== test/flush_ctrl_stim.txt ====
# code op1 op2 op3 op4 op5 bound, all hex
# 0 reset: op1 rst_addr; 1 event: op1 mask, op2 strobes, op3 dcache; 2 fence.t: sel pad trig burst pc
0 80000000 0 0 0 0 10
1 01 60 0 0 0 30
1 20 7c 0 0 0 30
1 40 7c 0 0 0 30
1 80 7c 0 0 0 30
1 30 7c 0 0 0 30
1 21 7c 0 0 0 30
1 04 fa 1 0 0 30
1 08 f9 0 0 0 30
1 02 f8 1 0 0 30
1 10 f8 0 0 0 30
2 0 28 3 1 00001000 120
2 1 60 2 0 00002a40 160
2 0 02 1 0 0000fffc 90
0 80000000 0 0 0 0 10
